// File: filelist.f
verilog/zx81_io_pkg.sv
verilog/io_bus_ctrl.sv
verilog/port_decode.sv
verilog/joystick_mapper.sv
verilog/sync_generator.sv
verilog/zx81_io_top.sv
tb/zx81_io_assertions.sv
tb/tb_zx81_io.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the ZX81 I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_zx81_io \
	--Mdir obj_dir -o sim_zx81_io &&
	./obj_dir/sim_zx81_io | tee sim.log
grep -q "Simulation PASSED" sim.log && echo "Result: pass" ||
	{ echo "Result: fail"; exit 1; }

// File: tb/tb_zx81_io.sv
// Testbench for the ZX81 I/O port block.
// Applies a table of port cycles under random response back-pressure,
// then measures hsync, NMI and vsync timing on the sync outputs.

`timescale 1ns/1ps

module tb_zx81_io;

	import zx81_io_pkg::*;

	localparam int CE_DIV_LOG2 = 4;
	localparam int CE_CLKS     = 1 << CE_DIV_LOG2;
	// hsync from count 15 to count 31, 207 counts per line
	localparam int HS_CLKS     = 16 * CE_CLKS;
	localparam int LINE_CLKS   = 207 * CE_CLKS;
	localparam logic [1:0] HS_BIT = 2'd2;
	localparam logic [1:0] VS_BIT = 2'd1;

	typedef struct packed {
		io_cfg_t    cfg;
		logic [4:0] key_rows;
		logic [4:0] joy;
		io_req_t    req;
		logic [7:0] exp_rsp;
		logic [7:0] exp_chroma;
	} row_t;

	logic         clk_sys = 1'b0;
	logic         reset;
	io_req_t      req;
	logic         req_valid;
	logic         req_ready;
	io_rsp_t      rsp;
	logic         rsp_valid;
	logic         rsp_ready = 1'b0;
	io_cfg_t      cfg;
	logic [4:0]   key_rows;
	logic [4:0]   joy;
	sync_t        sync;
	chroma_ctrl_t chroma;

	row_t        rows[$];
	string       names[$];
	bit          row_bad[$];
	logic [31:0] lfsr = 32'h27f1bf6d;
	int          tests;
	int          errors;
	int          high;
	int          period;
	int          nmi_low;
	bit          ok;

	zx81_io_top #(.CE_DIV_LOG2(CE_DIV_LOG2)) i_dut (.*);

	always #10 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	// Random back-pressure, one LFSR bit per clock
	always @(posedge clk_sys) begin
		#1;
		rsp_ready = lfsr[0];
		lfsr = lfsr_next(lfsr);
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic abort_run(input string what);
		$display("Timeout: %s", what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic log_result(input string name, input bit passed);
		tests++;
		if (!passed) begin
			errors++;
		end
		$display("test %-16s %s", name, passed ? "ok" : "failed");
	endtask

	task automatic check_int(input string name, input int exp, input int act);
		assert (act == exp) else $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		log_result(name, act == exp);
	endtask

	// cfg is {jsel, hz50, chroma81_en}
	task automatic add_row(input string name, input logic [3:0] c, input logic [4:0] k,
		input logic [4:0] j, input logic [15:0] a, input logic wr, input logic [7:0] d,
		input logic [7:0] e_rsp, input logic [7:0] e_chr);
		row_t r;
		r.cfg            = c;
		r.key_rows       = k;
		r.joy            = j;
		r.req.addr       = a;
		r.req.wdata.raw  = d;
		r.req.write      = wr;
		r.req.m1         = 1'b0;
		r.exp_rsp        = e_rsp;
		r.exp_chroma     = e_chr;
		rows.push_back(r);
		names.push_back(name);
		row_bad.push_back(1'b0);
	endtask

	task automatic build_table();
		// Keyboard, masked by the joystick per layout and address line
		add_row("kbd_idle",        4'b0010, 5'h1F, 5'h00, 16'hFEFE, 0, 8'h00, 8'h5F, 8'h00);
		add_row("kbd_keys_60hz",   4'b0000, 5'h1A, 5'h00, 16'hFEFE, 0, 8'h00, 8'h1A, 8'h00);
		add_row("cur_down_a12",    4'b0010, 5'h1F, 5'h04, 16'hEFFE, 0, 8'h00, 8'h4F, 8'h00);
		add_row("cur_down_a12_hi", 4'b0010, 5'h1F, 5'h04, 16'hF7FE, 0, 8'h00, 8'h5F, 8'h00);
		add_row("cur_left_a11",    4'b0010, 5'h1F, 5'h02, 16'hF7FE, 0, 8'h00, 8'h4F, 8'h00);
		add_row("cur_left_a12",    4'b0010, 5'h1F, 5'h02, 16'hEFFE, 0, 8'h00, 8'h5F, 8'h00);
		add_row("cur_fire_keys",   4'b0010, 5'h1D, 5'h10, 16'hEFFE, 0, 8'h00, 8'h5C, 8'h00);
		add_row("sin_fire",        4'b0110, 5'h1F, 5'h10, 16'hEFFE, 0, 8'h00, 8'h5E, 8'h00);
		add_row("sin_right",       4'b0110, 5'h1F, 5'h01, 16'hEFFE, 0, 8'h00, 8'h57, 8'h00);
		add_row("sin_up",          4'b0110, 5'h1F, 5'h08, 16'hEFFE, 0, 8'h00, 8'h5D, 8'h00);
		add_row("zx_right",        4'b1010, 5'h1F, 5'h01, 16'hEFFE, 0, 8'h00, 8'h5B, 8'h00);
		add_row("zx_down",         4'b1010, 5'h1F, 5'h04, 16'hEFFE, 0, 8'h00, 8'h4F, 8'h00);
		add_row("zx_fire_a12_hi",  4'b1010, 5'h1F, 5'h10, 16'hFEFE, 0, 8'h00, 8'h5F, 8'h00);
		// CHROMA81 register
		add_row("ch81_write",      4'b0011, 5'h1F, 5'h00, 16'h7FEF, 1, 8'h2B, 8'hFF, 8'h2B);
		add_row("ch81_read",       4'b0011, 5'h1F, 5'h00, 16'h7FEF, 0, 8'h00, 8'hDF, 8'h2B);
		add_row("ch81_off_read",   4'b0010, 5'h1F, 5'h00, 16'h7FEF, 0, 8'h00, 8'hFF, 8'h00);
		add_row("ch81_off_write",  4'b0010, 5'h1F, 5'h00, 16'h7FEF, 1, 8'h15, 8'hFF, 8'h00);
		// ZXpand commands, each read back
		add_row("zxp_high_wr",     4'b0010, 5'h1F, 5'h00, 16'hE007, 1, 8'hAA, 8'hFF, 8'h00);
		add_row("zxp_high_rd",     4'b0010, 5'h1F, 5'h00, 16'hE007, 0, 8'h00, 8'hF0, 8'h00);
		add_row("zxp_low_wr",      4'b0010, 5'h1F, 5'h00, 16'hE007, 1, 8'h55, 8'hFF, 8'h00);
		add_row("zxp_low_rd",      4'b0010, 5'h1F, 5'h00, 16'hE007, 0, 8'h00, 8'h0F, 8'h00);
		add_row("zxp_other_wr",    4'b0010, 5'h1F, 5'h00, 16'hE007, 1, 8'h3C, 8'hFF, 8'h00);
		add_row("zxp_other_rd",    4'b0010, 5'h1F, 5'h00, 16'hE007, 0, 8'h00, 8'hFF, 8'h00);
		add_row("zxp_joy_wr",      4'b0010, 5'h1F, 5'h18, 16'hE007, 1, 8'hA0, 8'hFF, 8'h00);
		add_row("zxp_joy_rd",      4'b0010, 5'h1F, 5'h00, 16'hE007, 0, 8'h00, 8'h70, 8'h00);
		add_row("kbd_unmasked",    4'b0010, 5'h1F, 5'h04, 16'hEFFE, 0, 8'h00, 8'h5F, 8'h00);
	endtask

	// Drives one request and returns one ns after its accept edge
	task automatic send(input io_req_t r);
		int n;
		req = r;
		req_valid = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!req_ready) begin
			n++;
			if (n > 100) abort_run("request was never accepted");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_sync(input logic [1:0] idx, input logic level, input int limit,
		output bit reached);
		int n;
		n = 0;
		reached = 1'b1;
		@(negedge clk_sys);
		while (sync[idx] != level) begin
			n++;
			if (n > limit) begin
				reached = 1'b0;
				return;
			end
			@(negedge clk_sys);
		end
	endtask

	// One I/O cycle without checking the answer, used by the sync tests
	task automatic cycle_io(input logic [15:0] addr, input logic wr);
		io_req_t r;
		int n;
		r = '0;
		r.addr = addr;
		r.write = wr;
		send(r);
		n = 0;
		@(negedge clk_sys);
		while (!(rsp_valid && rsp_ready)) begin
			n++;
			if (n > 100) abort_run("response to a sync test cycle never arrived");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1;
	endtask

	// ==============================
	// Table phase
	// ==============================

	task automatic run_table();
		for (int i = 0; i < rows.size(); i++) begin
			cfg = rows[i].cfg;
			key_rows = rows[i].key_rows;
			joy = rows[i].joy;
			send(rows[i].req);
			// Register writes land on the accept edge
			assert (chroma == rows[i].exp_chroma) else begin
				$display("[FAIL] %s chroma: expected %h, actual %h",
					names[i], rows[i].exp_chroma, chroma);
				row_bad[i] = 1'b1;
			end
		end
	endtask

	// Responses must come back one per row, in row order
	task automatic collect_table();
		int n;
		for (int i = 0; i < rows.size(); i++) begin
			n = 0;
			@(negedge clk_sys);
			while (!(rsp_valid && rsp_ready)) begin
				n++;
				if (n > 100) abort_run("a table response never arrived");
				@(negedge clk_sys);
			end
			assert (rsp == rows[i].exp_rsp) else begin
				$display("[FAIL] %s: expected %h, actual %h", names[i], rows[i].exp_rsp, rsp);
				row_bad[i] = 1'b1;
			end
			log_result(names[i], !row_bad[i]);
		end
	endtask

	// Counts clocks of one hsync pulse, the line period and NMI low time
	task automatic measure_line(output int hs_len, output int line_len, output int nmi_len);
		bit seen;
		wait_sync(HS_BIT, 1'b0, 2 * LINE_CLKS, seen);
		if (!seen) abort_run("hsync stuck high");
		wait_sync(HS_BIT, 1'b1, 2 * LINE_CLKS, seen);
		if (!seen) abort_run("hsync never rose");
		hs_len = 0;
		nmi_len = 0;
		while (sync.hsync && hs_len <= LINE_CLKS) begin
			hs_len++;
			if (!sync.nmi_n) nmi_len++;
			@(negedge clk_sys);
		end
		line_len = hs_len;
		while (!sync.hsync && line_len <= 2 * LINE_CLKS) begin
			line_len++;
			@(negedge clk_sys);
		end
	endtask

	initial begin
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		cfg = '0;
		key_rows = 5'h1F;
		joy = 5'h00;
		tests = 0;
		errors = 0;
		build_table();
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		fork
			run_table();
			collect_table();
		join
		@(negedge clk_sys);
		assert (!rsp_valid) else $display("An extra response appeared after the last table row");
		log_result("no_extra_rsp", !rsp_valid);

		// ==============================
		// Sync phase
		// ==============================

		// OUT FE switches the NMI generator on
		cycle_io(16'h00FE, 1'b1);
		measure_line(high, period, nmi_low);
		check_int("hsync_length", HS_CLKS, high);
		check_int("line_period", LINE_CLKS, period);
		check_int("nmi_on_low", HS_CLKS, nmi_low);

		cycle_io(16'h00FD, 1'b1);
		measure_line(high, period, nmi_low);
		check_int("nmi_off_low", 0, nmi_low);

		wait_sync(VS_BIT, 1'b0, LINE_CLKS, ok);
		if (!ok) abort_run("vsync stuck high before the keyboard read");
		cycle_io(16'hFEFE, 1'b0);
		wait_sync(VS_BIT, 1'b1, LINE_CLKS, ok);
		assert (ok) else $display("vsync did not rise within one line after a keyboard read");
		log_result("vsync_rise", ok);
		cycle_io(16'h00FF, 1'b1);
		wait_sync(VS_BIT, 1'b0, LINE_CLKS, ok);
		assert (ok) else $display("vsync did not fall within one line after an OUT");
		log_result("vsync_fall", ok);

		// Bus and sync properties watched over the whole run
		assert (i_dut.i_assert.fail_cnt == 0)
			else $display("Bound bus or sync assertions failed %0d times",
				i_dut.i_assert.fail_cnt);
		log_result("bound_checks", i_dut.i_assert.fail_cnt == 0);

		$display("Tests run: %0d, failed: %0d", tests, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: tb/zx81_io_assertions.sv
// Protocol and sync checks for the ZX81 I/O block.
// Bound into the top level, where the bus controller and sync
// generator outputs meet.

`timescale 1ns/1ps

module zx81_io_assertions (
	input logic                 clk_sys,
	input logic                 reset,
	input logic                 req_valid,
	input logic                 rsp_valid,
	input logic                 rsp_ready,
	input zx81_io_pkg::io_rsp_t rsp,
	input zx81_io_pkg::sync_t   sync
);

	// Number of failed assertions
	int fail_cnt = 0;

	// ==============================
	// Response stream
	// ==============================

	// A stalled answer stays put
	rsp_held: assert property (@(posedge clk_sys) disable iff (reset)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
		else begin
			fail_cnt++;
			$error("Response changed or vanished while stalled");
		end

	// Empty slot always takes a request
	ready_when_empty: assert property (@(posedge clk_sys) disable iff (reset)
		(req_valid && !rsp_valid) |=> rsp_valid)
		else begin
			fail_cnt++;
			$error("Request into an empty response slot was not taken");
		end

	// ==============================
	// Sync
	// ==============================

	nmi_in_hsync: assert property (@(posedge clk_sys) disable iff (reset)
		!sync.nmi_n |-> sync.hsync)
		else begin
			fail_cnt++;
			$error("nmi_n low outside hsync");
		end

endmodule

bind zx81_io_top zx81_io_assertions i_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.req_valid (req_valid),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.rsp       (rsp),
	.sync      (sync)
);

// File: verilog/zx81_io_top.sv
// Top level of the ZX81 I/O port block.
// Takes CPU I/O cycles on a valid/ready request stream, answers on a
// response stream, and drives the sync and CHROMA81 outputs.

`timescale 1ns/1ps

module zx81_io_top #(
	parameter int CE_DIV_LOG2 = 4
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	input  zx81_io_pkg::io_req_t      req,
	input  logic                      req_valid,
	output logic                      req_ready,

	output zx81_io_pkg::io_rsp_t      rsp,
	output logic                      rsp_valid,
	input  logic                      rsp_ready,

	input  zx81_io_pkg::io_cfg_t      cfg,
	// Active low key rows, active high joystick
	input  logic [4:0]                key_rows,
	input  logic [4:0]                joy,

	output zx81_io_pkg::sync_t        sync,
	output zx81_io_pkg::chroma_ctrl_t chroma
);

	logic                 acc;
	zx81_io_pkg::io_req_t acc_req;
	logic [7:0]           rd_data;
	logic                 kbd_rd;
	logic                 zxp_sel;
	logic [4:0]           key_cols;
	logic [7:0]           zxp_data;

	// ==============================
	// Bus side
	// ==============================

	io_bus_ctrl i_bus (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.acc       (acc),
		.acc_req   (acc_req),
		.rd_data   (rd_data)
	);

	port_decode i_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.acc      (acc),
		.acc_req  (acc_req),
		.cfg      (cfg),
		.key_cols (key_cols),
		.zxp_data (zxp_data),
		.rd_data  (rd_data),
		.kbd_rd   (kbd_rd),
		.zxp_sel  (zxp_sel),
		.chroma   (chroma)
	);

	// ==============================
	// Joystick and sync
	// ==============================

	joystick_mapper i_joy (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.acc      (acc),
		.acc_req  (acc_req),
		.zxp_sel  (zxp_sel),
		.jsel     (cfg.jsel),
		.joy      (joy),
		.key_rows (key_rows),
		.key_cols (key_cols),
		.zxp_data (zxp_data)
	);

	sync_generator #(
		.CE_DIV_LOG2 (CE_DIV_LOG2)
	) i_sync (
		.clk_sys (clk_sys),
		.reset   (reset),
		.acc     (acc),
		.acc_req (acc_req),
		.kbd_rd  (kbd_rd),
		.sync    (sync)
	);

endmodule

// File: verilog/sync_generator.sv
// ZX81 line sync and NMI generation.
// Divides clk_sys down to the 3.25 MHz enable, counts 207 enables per
// line, and drives hsync, the NMI latch and the keyboard-driven vsync.

`timescale 1ns/1ps

module sync_generator #(
	parameter int CE_DIV_LOG2 = 4
) (
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic                 acc,
	input  zx81_io_pkg::io_req_t acc_req,
	input  logic                 kbd_rd,

	output zx81_io_pkg::sync_t   sync
);

	import zx81_io_pkg::*;

	logic [CE_DIV_LOG2-1:0] ce_cnt;
	logic                   ce_3m25;
	logic [7:0]             line_cnt;
	logic                   hsync;
	logic                   nmi_latch;
	logic                   vs;
	logic                   vsync;
	logic                   out_cycle;

	assign out_cycle = acc & acc_req.write;

	// ==============================
	// 3.25 MHz enable
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_cnt <= '0;
		end else begin
			ce_cnt <= ce_cnt + 1'b1;
		end
	end

	assign ce_3m25 = &ce_cnt;

	// ==============================
	// Line counter and hsync
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			line_cnt <= '0;
			hsync    <= 1'b0;
		end else if (acc & acc_req.m1) begin
			// Interrupt acknowledge restarts the line
			line_cnt <= '0;
			hsync    <= 1'b0;
		end else if (ce_3m25) begin
			line_cnt <= (line_cnt == LINE_LAST) ? 8'd0 : line_cnt + 8'd1;
			if (line_cnt == HSYNC_ON) begin
				hsync <= 1'b1;
			end
			if (line_cnt == HSYNC_OFF) begin
				hsync <= 1'b0;
			end
		end
	end

	// ==============================
	// NMI latch and vsync
	// ==============================

	// OUT FE turns the NMI generator on, OUT FD turns it off
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi_latch <= 1'b0;
		end else if (out_cycle & (acc_req.addr[0] ^ acc_req.addr[1])) begin
			nmi_latch <= acc_req.addr[1];
		end
	end

	// Keyboard read starts vertical sync, any OUT ends it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vs    <= 1'b0;
			vsync <= 1'b0;
		end else begin
			if (out_cycle & ~nmi_latch) begin
				vs <= 1'b0;
			end
			if (kbd_rd & ~nmi_latch) begin
				vs <= 1'b1;
			end
			// Clean copy, only moves outside hsync
			if (~hsync) begin
				vsync <= vs;
			end
		end
	end

	assign sync = '{hsync: hsync, vsync: vsync, nmi_n: ~(nmi_latch & hsync)};

endmodule

// File: verilog/joystick_mapper.sv
// Joystick to keyboard mapping and the ZXpand joystick port.
// Folds the joystick into the key columns in Cursor, Sinclair or ZX81
// layout, and answers ZXpand commands written to port E007.

`timescale 1ns/1ps

module joystick_mapper (
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic                 acc,
	input  zx81_io_pkg::io_req_t acc_req,
	input  logic                 zxp_sel,

	input  logic [1:0]           jsel,
	// right, left, down, up, fire from bit 0
	input  logic [4:0]           joy,
	input  logic [4:0]           key_rows,

	output logic [4:0]           key_cols,
	output logic [7:0]           zxp_data
);

	import zx81_io_pkg::*;

	logic       zxp_use;
	logic       cursor;
	logic [4:0] joy_zx;
	logic [4:0] joy_s1;
	logic [4:0] joy_c1;
	logic [4:0] joy_c2;
	logic [4:0] joy_mask;

	// ==============================
	// Key column mapping
	// ==============================

	assign cursor = (jsel == 2'd0);

	// ZX81 layout on keys 6 7 8 9 0
	assign joy_zx = {5{jsel[1]}} & {joy[2], joy[3], joy[0], joy[1], joy[4]};

	// Sinclair 1 on the same row
	assign joy_s1 = {5{jsel[0]}} & {joy[1:0], joy[2], joy[3], joy[4]};

	// Cursor 6 7 8 and 0, with left on key 5 of the other half row
	assign joy_c1 = {5{cursor}} & {joy[2], joy[3], joy[0], 1'b0, joy[4]};
	assign joy_c2 = {5{cursor}} & {joy[1], 4'b0000};

	// A12 low selects the 6..0 row, A11 low the 1..5 row
	assign joy_mask = {5{zxp_use}}
		| (({5{acc_req.addr[12]}} | ~(joy_s1 | joy_c1 | joy_zx))
		& ({5{acc_req.addr[11]}} | ~joy_c2));

	assign key_cols = key_rows & joy_mask;

	// ==============================
	// ZXpand joystick port
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zxp_use  <= 1'b0;
			zxp_data <= 8'hFF;
		end else if (acc & acc_req.write & zxp_sel) begin
			case (acc_req.wdata.raw)
				ZXP_CMD_HIGH: zxp_data <= ZXP_VAL_HIGH;
				ZXP_CMD_LOW:  zxp_data <= ZXP_VAL_LOW;
				ZXP_CMD_JOY: begin
					// Joystick now read through ZXpand, keys left alone
					zxp_use  <= 1'b1;
					zxp_data <= {~joy[3:0], ~joy[4], 3'b000};
				end
				default: zxp_data <= 8'hFF;
			endcase
		end
	end

endmodule

// File: verilog/port_decode.sv
// Port address decode for the ZX81 I/O block.
// Selects keyboard, ZXpand and CHROMA81 ports for each accepted cycle,
// holds the CHROMA81 control register and builds the read byte.

`timescale 1ns/1ps

module port_decode (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Accepted cycle
	input  logic                      acc,
	input  zx81_io_pkg::io_req_t      acc_req,

	input  zx81_io_pkg::io_cfg_t      cfg,

	// From the joystick mapper
	input  logic [4:0]                key_cols,
	input  logic [7:0]                zxp_data,

	output logic [7:0]                rd_data,
	output logic                      kbd_rd,
	output logic                      zxp_sel,
	output zx81_io_pkg::chroma_ctrl_t chroma
);

	import zx81_io_pkg::*;

	logic is_rd;
	logic is_wr;
	logic kbd_sel;
	logic ch81_sel;

	// Tape input is not wired in this block
	localparam logic TAPE_IN = 1'b0;

	// ==============================
	// Address decode
	// ==============================

	// Interrupt acknowledge is neither an IN nor an OUT
	assign is_rd = ~acc_req.write & ~acc_req.m1;
	assign is_wr =  acc_req.write & ~acc_req.m1;

	// Keyboard answers on any even port
	assign kbd_sel  = ~acc_req.addr[0];
	assign zxp_sel  = ~acc_req.m1 & (acc_req.addr == ZXP_PORT);
	assign ch81_sel = ~acc_req.m1 & (acc_req.addr == CH81_PORT) & cfg.chroma81_en;

	assign kbd_rd = acc & is_rd & kbd_sel;

	// ==============================
	// Read data mux
	// ==============================

	always_comb begin
		casez ({is_rd & kbd_sel, is_rd & zxp_sel, is_rd & ch81_sel})
			3'b1??: rd_data = {TAPE_IN, cfg.hz50, 1'b0, key_cols};
			3'b01?: rd_data = zxp_data;
			3'b001: rd_data = CH81_ID;
			default: rd_data = 8'hFF;
		endcase
	end

	// ==============================
	// CHROMA81 control register
	// ==============================

	// Held at zero while the add-on is switched off
	always_ff @(posedge clk_sys) begin
		if (reset | ~cfg.chroma81_en) begin
			chroma <= '0;
		end else if (acc & is_wr & ch81_sel) begin
			chroma <= acc_req.wdata.chroma;
		end
	end

endmodule

// File: verilog/io_bus_ctrl.sv
// Request/response handshake for the I/O port block.
// Accepts one CPU I/O cycle per clock, hands it to the port logic
// for that clock and returns the answer from a one-entry register.

`timescale 1ns/1ps

module io_bus_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,

	// Request stream from the CPU side
	input  zx81_io_pkg::io_req_t req,
	input  logic                 req_valid,
	output logic                 req_ready,

	// Response stream to the CPU side
	output zx81_io_pkg::io_rsp_t rsp,
	output logic                 rsp_valid,
	input  logic                 rsp_ready,

	// Accepted cycle towards the port blocks
	output logic                 acc,
	output zx81_io_pkg::io_req_t acc_req,
	input  logic [7:0]           rd_data
);

	// ==============================
	// Flow control
	// ==============================

	// Room when the slot is empty or drains this clock
	assign req_ready = ~rsp_valid | rsp_ready;
	assign acc       = req_valid & req_ready;

	// Port blocks only look at acc_req while acc is high
	assign acc_req = req;

	// ==============================
	// Response slot
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else if (acc) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	// Read answer or FF for an OUT
	always_ff @(posedge clk_sys) begin
		if (acc) begin
			rsp <= req.write ? 8'hFF : rd_data;
		end
	end

endmodule

// File: verilog/zx81_io_pkg.sv
// Shared types and port constants for the ZX81 I/O port block.
// Every module of the block imports this package; the CPU side
// uses io_req_t and io_rsp_t for its request and response streams.

package zx81_io_pkg;

	// ==============================
	// Bus payloads
	// ==============================

	// CHROMA81 control byte, as written to 7FEF
	typedef struct packed {
		logic [1:0] unused;
		logic       enable;
		logic       attr_mode;
		logic [3:0] border;
	} chroma_ctrl_t;

	// OUT data byte, plain for ZXpand commands or as a CHROMA81 control word
	typedef union packed {
		logic [7:0]   raw;
		chroma_ctrl_t chroma;
	} io_wdata_u;

	// One CPU I/O cycle
	typedef struct packed {
		logic [15:0] addr;
		io_wdata_u   wdata;
		logic        write;
		logic        m1;
	} io_req_t;

	// Read data back to the CPU, FF for writes
	typedef logic [7:0] io_rsp_t;

	// ==============================
	// Static settings and outputs
	// ==============================

	// jsel: 0 Cursor, 1 Sinclair, 2 ZX81
	typedef struct packed {
		logic [1:0] jsel;
		logic       hz50;
		logic       chroma81_en;
	} io_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic nmi_n;
	} sync_t;

	// Port addresses and ids
	localparam logic [15:0] ZXP_PORT  = 16'hE007;
	localparam logic [15:0] CH81_PORT = 16'h7FEF;
	localparam logic [7:0]  CH81_ID   = 8'hDF;

	// ZXpand commands and the byte each one leaves in the port
	localparam logic [7:0] ZXP_CMD_HIGH = 8'hAA;
	localparam logic [7:0] ZXP_VAL_HIGH = 8'hF0;
	localparam logic [7:0] ZXP_CMD_LOW  = 8'h55;
	localparam logic [7:0] ZXP_VAL_LOW  = 8'h0F;
	localparam logic [7:0] ZXP_CMD_JOY  = 8'hA0;

	// Line timing in 3.25 MHz enables
	localparam logic [7:0] HSYNC_ON  = 8'd15;
	localparam logic [7:0] HSYNC_OFF = 8'd31;
	localparam logic [7:0] LINE_LAST = 8'd206;

endpackage
